//--- source/dcache_geom_pkg.sv
package dcache_geom_pkg;

   // Processor word and address size
   localparam int unsigned ADDR_WIDTH = 32;
   localparam int unsigned DATA_WIDTH = 32;

   // 16-byte blocks, 64 sets
   localparam int unsigned BLOCK_WIDTH = 4;
   localparam int unsigned SET_WIDTH = 6;
   localparam int unsigned WORD_SEL_WIDTH = 2;

   // Everything above the set index is tag
   localparam int unsigned TAG_WIDTH = ADDR_WIDTH - SET_WIDTH - BLOCK_WIDTH;

   // Each way RAM holds all words of all sets
   localparam int unsigned WAY_RAM_AW = SET_WIDTH + WORD_SEL_WIDTH;

   localparam int unsigned NUM_WAYS = 2;

   // Tag entry is {lru, way1 valid, way1 tag, way0 valid, way0 tag}
   localparam int unsigned TAG_ENTRY_WIDTH = NUM_WAYS * (TAG_WIDTH + 1) + 1;

   // One address, two decodings
   typedef union packed {
      // Tag RAM side
      struct packed {
         logic [TAG_WIDTH-1:0]                  tag;
         logic [SET_WIDTH-1:0]                  set;
         logic [WORD_SEL_WIDTH-1:0]             word;
         logic [BLOCK_WIDTH-WORD_SEL_WIDTH-1:0] byte_off;
      } line;
      // Data RAM side folds set and word into one RAM index
      struct packed {
         logic [TAG_WIDTH-1:0]                  tag;
         logic [WAY_RAM_AW-1:0]                 ram_word;
         logic [BLOCK_WIDTH-WORD_SEL_WIDTH-1:0] byte_off;
      } ram;
   } dcache_addr_u;

endpackage

//--- source/dcache_spr_pkg.sv
package dcache_spr_pkg;

   // SPR bus address size
   localparam int unsigned SPR_ADDR_WIDTH = 16;

   // Data cache block flush register
   localparam logic [SPR_ADDR_WIDTH-1:0] SPR_DCBFR_ADDR = 16'h3002;

   // Data cache block invalidate register
   localparam logic [SPR_ADDR_WIDTH-1:0] SPR_DCBIR_ADDR = 16'h3003;

   // Both registers take a byte address in their data word
   // and only the set index of it matters here
   // A flush is the same as an invalidate since writes go through

endpackage

//--- source/dcache_sdpram.sv
`timescale 1ns/1ps

module dcache_sdpram #(
   parameter int unsigned ADDR_WIDTH = 8,
   parameter int unsigned DATA_WIDTH = 32
) (
   input  logic                  clk,
   input  logic [ADDR_WIDTH-1:0] raddr_i,
   input  logic [ADDR_WIDTH-1:0] waddr_i,
   input  logic                  we_i,
   input  logic [DATA_WIDTH-1:0] din_i,
   output logic [DATA_WIDTH-1:0] dout_o
);

   // Storage array, one entry per address
   logic [DATA_WIDTH-1:0] mem [0:(1 << ADDR_WIDTH)-1];

   // Write port
   always_ff @(posedge clk) begin
      if (we_i) begin
         mem[waddr_i] <= din_i;
      end
   end

   // Registered read port
   // A write to the address being read is forwarded
   // so the reader never sees the old word
   always_ff @(posedge clk) begin
      if (we_i && (waddr_i == raddr_i)) begin
         dout_o <= din_i;
      end else begin
         dout_o <= mem[raddr_i];
      end
   end

endmodule

//--- source/dcache_tag_lookup.sv
`timescale 1ns/1ps

module dcache_tag_lookup import dcache_geom_pkg::*; #(
   parameter int unsigned TAG_RAM_AW = SET_WIDTH
) (
   input  logic                  clk,
   input  dcache_addr_u          rd_adr_i,
   input  logic [TAG_RAM_AW-1:0] wr_set_i,
   input  logic                  lru_touch_i,
   input  logic                  save_entry_i,
   input  logic                  victim_clear_i,
   input  logic                  fill_i,
   input  logic [TAG_WIDTH-1:0]  fill_tag_i,
   input  logic                  inval_i,
   output logic [NUM_WAYS-1:0]   way_hit_o,
   output logic [NUM_WAYS-1:0]   victim_way_o
);

   // One way's slice of the entry is {valid, tag}
   localparam int unsigned WAY_FIELD = TAG_WIDTH + 1;
   localparam int unsigned LRU_POS = TAG_ENTRY_WIDTH - 1;

   logic [TAG_ENTRY_WIDTH-1:0] rd_entry;
   logic [TAG_ENTRY_WIDTH-1:0] wr_entry;
   logic [TAG_ENTRY_WIDTH-1:0] saved_entry;
   logic                       tag_we;

   // Any strobe from the controller writes the set
   assign tag_we = lru_touch_i | save_entry_i | victim_clear_i | fill_i | inval_i;

   // Hit needs the valid bit and a matching tag
   for (genvar w = 0; w < NUM_WAYS; w++) begin : g_cmp
      assign way_hit_o[w] = rd_entry[w*WAY_FIELD + TAG_WIDTH] &&
                            (rd_entry[w*WAY_FIELD +: TAG_WIDTH] == rd_adr_i.line.tag);
      // LRU bit holds the index of the way to replace
      assign victim_way_o[w] = (saved_entry[LRU_POS] == 1'(w));
   end

   // Entry as read at the miss, kept for the whole refill
   always_ff @(posedge clk) begin
      if (save_entry_i) begin
         saved_entry <= rd_entry;
      end
   end

   // New entry for the write port
   always_comb begin
      wr_entry = rd_entry;
      // Refill edits start from the entry seen at the miss
      if (victim_clear_i || fill_i) begin
         wr_entry = saved_entry;
      end
      for (int w = 0; w < NUM_WAYS; w++) begin
         // First refill word makes the victim unusable
         if (victim_clear_i && victim_way_o[w]) begin
            wr_entry[w*WAY_FIELD + TAG_WIDTH] = 1'b0;
         end
         // Last refill word installs the new tag
         if (fill_i && victim_way_o[w]) begin
            wr_entry[w*WAY_FIELD +: WAY_FIELD] = {1'b1, fill_tag_i};
         end
      end
      // Freshly filled way is most recent
      if (fill_i) begin
         wr_entry[LRU_POS] = ~saved_entry[LRU_POS];
      end
      // Hit on way 0 leaves way 1 as LRU and vice versa
      if (lru_touch_i) begin
         wr_entry[LRU_POS] = way_hit_o[0];
      end
      if (inval_i) begin
         wr_entry = '0;
      end
   end

   dcache_sdpram #(
      .ADDR_WIDTH (TAG_RAM_AW),
      .DATA_WIDTH (TAG_ENTRY_WIDTH)
   ) tag_ram (
      .clk     (clk),
      .raddr_i (rd_adr_i.line.set),
      .waddr_i (wr_set_i),
      .we_i    (tag_we),
      .din_i   (wr_entry),
      .dout_o  (rd_entry)
   );

endmodule

//--- source/dcache_data_ways.sv
`timescale 1ns/1ps

module dcache_data_ways import dcache_geom_pkg::*; #(
   parameter int unsigned DATA_RAM_AW = WAY_RAM_AW
) (
   input  logic                    clk,
   input  dcache_addr_u            rd_adr_i,
   input  dcache_addr_u            cpu_adr_i,
   input  dcache_addr_u            refill_adr_i,
   input  logic                    cpu_write_i,
   input  logic [NUM_WAYS-1:0]     way_hit_i,
   input  logic [NUM_WAYS-1:0]     victim_way_i,
   input  logic                    rd_victim_i,
   input  logic [DATA_WIDTH/8-1:0] cpu_bsel_i,
   input  logic [DATA_WIDTH-1:0]   cpu_dat_i,
   input  logic                    refill_write_i,
   input  logic [DATA_WIDTH-1:0]   refill_dat_i,
   output logic [DATA_WIDTH-1:0]   cpu_dat_o
);

   logic [DATA_WIDTH-1:0]  way_dout [NUM_WAYS];
   logic [DATA_WIDTH-1:0]  hit_dat;
   logic [DATA_WIDTH-1:0]  merged_dat;
   logic [DATA_WIDTH-1:0]  way_din;
   logic [DATA_RAM_AW-1:0] way_waddr;
   logic [NUM_WAYS-1:0]    rd_sel;

   // Refill reads come from the way being filled
   assign rd_sel = rd_victim_i ? victim_way_i : way_hit_i;

   always_comb begin
      hit_dat = way_dout[0];
      cpu_dat_o = way_dout[0];
      for (int w = 1; w < NUM_WAYS; w++) begin
         if (way_hit_i[w]) begin
            hit_dat = way_dout[w];
         end
         if (rd_sel[w]) begin
            cpu_dat_o = way_dout[w];
         end
      end
   end

   // Write hit keeps the unselected bytes of the cached word
   always_comb begin
      for (int b = 0; b < DATA_WIDTH/8; b++) begin
         merged_dat[8*b +: 8] = cpu_bsel_i[b] ? cpu_dat_i[8*b +: 8] : hit_dat[8*b +: 8];
      end
   end

   // CPU writes and refill writes never overlap
   assign way_din = cpu_write_i ? merged_dat : refill_dat_i;
   assign way_waddr = cpu_write_i ? cpu_adr_i.ram.ram_word : refill_adr_i.ram.ram_word;

   for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
      logic way_we;

      // Misses on a write find no way and write nothing
      assign way_we = (cpu_write_i && way_hit_i[w]) || (refill_write_i && victim_way_i[w]);

      dcache_sdpram #(
         .ADDR_WIDTH (DATA_RAM_AW),
         .DATA_WIDTH (DATA_WIDTH)
      ) data_ram (
         .clk     (clk),
         .raddr_i (rd_adr_i.ram.ram_word),
         .waddr_i (way_waddr),
         .we_i    (way_we),
         .din_i   (way_din),
         .dout_o  (way_dout[w])
      );
   end

endmodule

//--- source/dcache_ctrl.sv
`timescale 1ns/1ps

module dcache_ctrl import dcache_geom_pkg::*, dcache_spr_pkg::*; (
   input  logic                      clk,
   input  logic                      rst,
   input  logic                      cpu_req_i,
   input  logic                      cpu_we_i,
   input  dcache_addr_u              cpu_adr_i,
   input  logic                      refill_we_i,
   input  dcache_addr_u              refill_adr_i,
   input  logic                      spr_bus_stb_i,
   input  logic                      spr_bus_we_i,
   input  logic [SPR_ADDR_WIDTH-1:0] spr_bus_addr_i,
   input  logic [DATA_WIDTH-1:0]     spr_bus_dat_i,
   input  logic [NUM_WAYS-1:0]       way_hit_i,
   output logic                      cpu_ack_o,
   output logic                      refill_req_o,
   output logic                      refill_done_o,
   output logic                      spr_bus_ack_o,
   output logic [SET_WIDTH-1:0]      tag_wr_set_o,
   output logic                      lru_touch_o,
   output logic                      save_entry_o,
   output logic                      victim_clear_o,
   output logic                      fill_o,
   output logic                      inval_o,
   output logic                      cpu_write_o,
   output logic                      refill_write_o,
   output logic                      rd_victim_o
);

   localparam logic [2:0] ST_IDLE   = 3'd0;
   localparam logic [2:0] ST_READ   = 3'd1;
   localparam logic [2:0] ST_WRITE  = 3'd2;
   localparam logic [2:0] ST_REFILL = 3'd3;
   localparam logic [2:0] ST_INVAL  = 3'd4;

   localparam int unsigned BLOCK_WORDS = 1 << WORD_SEL_WIDTH;

   logic [2:0]                state;
   logic [SET_WIDTH-1:0]      inval_set;
   logic [BLOCK_WORDS-1:0]    refill_valid;
   logic [BLOCK_WORDS-1:0]    refill_valid_r;
   logic                      miss_pend;
   dcache_addr_u              spr_adr;
   logic                      st_idle;
   logic                      st_read;
   logic                      st_write;
   logic                      st_refill;
   logic                      st_inval;
   logic                      hit;
   logic                      invalidate;
   logic [WORD_SEL_WIDTH-1:0] next_word;
   logic                      refill_done;
   logic                      refill_hit;

   assign st_idle = (state == ST_IDLE);
   assign st_read = (state == ST_READ);
   assign st_write = (state == ST_WRITE);
   assign st_refill = (state == ST_REFILL);
   assign st_inval = (state == ST_INVAL);

   assign hit = |way_hit_i;

   // Block flush and block invalidate both clear the set
   assign invalidate = spr_bus_stb_i && spr_bus_we_i &&
                       ((spr_bus_addr_i == SPR_DCBFR_ADDR) ||
                        (spr_bus_addr_i == SPR_DCBIR_ADDR));

   // SPR data carries a byte address of the block
   assign spr_adr = spr_bus_dat_i;

   // Words arrive in wrap order, so the final one
   // is followed by a word that is already in
   assign next_word = refill_adr_i.line.word + 1'b1;
   assign refill_done = st_refill && refill_we_i && refill_valid[next_word];

   // Delayed vector means the RAM read port already shows the word
   assign refill_hit = st_refill && miss_pend && cpu_req_i &&
                       refill_valid_r[cpu_adr_i.line.word];

   // CPU side
   assign cpu_ack_o = (cpu_req_i && ((st_read && hit) || st_write)) || refill_hit;

   // Memory side
   assign refill_req_o = st_refill;
   assign refill_done_o = refill_done;

   // SPR side
   assign spr_bus_ack_o = st_inval && invalidate;

   // Each tag strobe comes from one state
   assign lru_touch_o = st_read && cpu_req_i && hit;
   assign save_entry_o = st_read && cpu_req_i && !hit;
   assign victim_clear_o = st_refill && refill_we_i && (refill_valid == '0);
   assign fill_o = refill_done;
   assign inval_o = st_inval;

   // Data strobes
   assign cpu_write_o = st_write && cpu_req_i;
   assign refill_write_o = st_refill && refill_we_i;
   assign rd_victim_o = st_refill;

   // Set written by the tag strobes
   always_comb begin
      if (st_refill) begin
         tag_wr_set_o = refill_adr_i.line.set;
      end else if (st_inval) begin
         tag_wr_set_o = inval_set;
      end else begin
         tag_wr_set_o = cpu_adr_i.line.set;
      end
   end

   // Set to clear is refreshed while the strobe stays up
   always_ff @(posedge clk) begin
      if (invalidate && (st_idle || st_inval)) begin
         inval_set <= spr_adr.line.set;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= ST_IDLE;
         refill_valid <= '0;
         refill_valid_r <= '0;
         miss_pend <= 1'b0;
      end else begin
         refill_valid_r <= refill_valid;
         case (state)
            ST_IDLE: begin
               // SPR invalidation goes ahead of the CPU
               if (invalidate) begin
                  state <= ST_INVAL;
               end else if (cpu_req_i && cpu_we_i) begin
                  state <= ST_WRITE;
               end else if (cpu_req_i) begin
                  state <= ST_READ;
               end
            end
            ST_READ: begin
               if (!cpu_req_i || hit) begin
                  state <= ST_IDLE;
               end else begin
                  // Miss starts a fresh block
                  refill_valid <= '0;
                  refill_valid_r <= '0;
                  miss_pend <= 1'b1;
                  state <= ST_REFILL;
               end
            end
            ST_WRITE: begin
               state <= ST_IDLE;
            end
            ST_REFILL: begin
               // Only the missed request is served from here
               if (refill_hit) begin
                  miss_pend <= 1'b0;
               end
               if (refill_we_i) begin
                  refill_valid[refill_adr_i.line.word] <= 1'b1;
                  if (refill_done) begin
                     miss_pend <= 1'b0;
                     state <= ST_IDLE;
                  end
               end
            end
            ST_INVAL: begin
               if (!invalidate) begin
                  state <= ST_IDLE;
               end
            end
            default: begin
               state <= ST_IDLE;
            end
         endcase
      end
   end

endmodule

//--- source/dcache_top.sv
`timescale 1ns/1ps

module dcache_top import dcache_geom_pkg::*, dcache_spr_pkg::*; #(
   parameter int unsigned TAG_RAM_AW  = SET_WIDTH,
   parameter int unsigned DATA_RAM_AW = WAY_RAM_AW
) (
   input  logic                      clk,
   input  logic                      rst,
   // CPU load/store port
   input  logic                      cpu_req_i,
   input  logic                      cpu_we_i,
   input  logic [DATA_WIDTH/8-1:0]   cpu_bsel_i,
   input  logic [ADDR_WIDTH-1:0]     cpu_adr_i,
   input  logic [DATA_WIDTH-1:0]     cpu_dat_i,
   output logic [DATA_WIDTH-1:0]     cpu_dat_o,
   output logic                      cpu_ack_o,
   // Block refill from memory
   output logic                      refill_req_o,
   output logic                      refill_done_o,
   input  logic                      refill_we_i,
   input  logic [ADDR_WIDTH-1:0]     refill_adr_i,
   input  logic [DATA_WIDTH-1:0]     refill_dat_i,
   // SPR bus
   input  logic                      spr_bus_stb_i,
   input  logic                      spr_bus_we_i,
   input  logic [SPR_ADDR_WIDTH-1:0] spr_bus_addr_i,
   input  logic [DATA_WIDTH-1:0]     spr_bus_dat_i,
   output logic                      spr_bus_ack_o
);

   logic [NUM_WAYS-1:0]  way_hit;
   logic [NUM_WAYS-1:0]  victim_way;
   logic [SET_WIDTH-1:0] tag_wr_set;
   logic                 lru_touch;
   logic                 save_entry;
   logic                 victim_clear;
   logic                 fill;
   logic                 inval;
   logic                 cpu_write;
   logic                 refill_write;
   logic                 rd_victim;

   dcache_ctrl ctrl0 (
      .clk            (clk),
      .rst            (rst),
      .cpu_req_i      (cpu_req_i),
      .cpu_we_i       (cpu_we_i),
      .cpu_adr_i      (cpu_adr_i),
      .refill_we_i    (refill_we_i),
      .refill_adr_i   (refill_adr_i),
      .spr_bus_stb_i  (spr_bus_stb_i),
      .spr_bus_we_i   (spr_bus_we_i),
      .spr_bus_addr_i (spr_bus_addr_i),
      .spr_bus_dat_i  (spr_bus_dat_i),
      .way_hit_i      (way_hit),
      .cpu_ack_o      (cpu_ack_o),
      .refill_req_o   (refill_req_o),
      .refill_done_o  (refill_done_o),
      .spr_bus_ack_o  (spr_bus_ack_o),
      .tag_wr_set_o   (tag_wr_set),
      .lru_touch_o    (lru_touch),
      .save_entry_o   (save_entry),
      .victim_clear_o (victim_clear),
      .fill_o         (fill),
      .inval_o        (inval),
      .cpu_write_o    (cpu_write),
      .refill_write_o (refill_write),
      .rd_victim_o    (rd_victim)
   );

   // Tag RAM is read with the CPU address, new tags come from the refill address
   dcache_tag_lookup #(
      .TAG_RAM_AW (TAG_RAM_AW)
   ) tags0 (
      .clk            (clk),
      .rd_adr_i       (cpu_adr_i),
      .wr_set_i       (tag_wr_set),
      .lru_touch_i    (lru_touch),
      .save_entry_i   (save_entry),
      .victim_clear_i (victim_clear),
      .fill_i         (fill),
      .fill_tag_i     (refill_adr_i[ADDR_WIDTH-1 -: TAG_WIDTH]),
      .inval_i        (inval),
      .way_hit_o      (way_hit),
      .victim_way_o   (victim_way)
   );

   dcache_data_ways #(
      .DATA_RAM_AW (DATA_RAM_AW)
   ) ways0 (
      .clk            (clk),
      .rd_adr_i       (cpu_adr_i),
      .cpu_adr_i      (cpu_adr_i),
      .refill_adr_i   (refill_adr_i),
      .cpu_write_i    (cpu_write),
      .way_hit_i      (way_hit),
      .victim_way_i   (victim_way),
      .rd_victim_i    (rd_victim),
      .cpu_bsel_i     (cpu_bsel_i),
      .cpu_dat_i      (cpu_dat_i),
      .refill_write_i (refill_write),
      .refill_dat_i   (refill_dat_i),
      .cpu_dat_o      (cpu_dat_o)
   );

endmodule

//--- sim/dcache_chk.sv
`timescale 1ns/1ps

module dcache_chk (
   input logic clk,
   input logic rst,
   input logic cpu_req_i,
   input logic cpu_ack_i,
   input logic spr_bus_stb_i,
   input logic spr_bus_ack_i,
   input logic refill_req_i,
   input logic refill_done_i
);

   // Number of property failures so far
   int error_count = 0;

   // CPU ack answers a pending request only
   ack_needs_req: assert property (@(posedge clk) disable iff (rst)
      cpu_ack_i |-> cpu_req_i)
      else begin
         $error("cpu_ack_o raised without cpu_req_i");
         error_count++;
      end

   // SPR ack answers a live strobe only
   spr_ack_needs_stb: assert property (@(posedge clk) disable iff (rst)
      spr_bus_ack_i |-> spr_bus_stb_i)
      else begin
         $error("spr_bus_ack_o raised without spr_bus_stb_i");
         error_count++;
      end

   // End of refill falls inside the refill request
   done_needs_req: assert property (@(posedge clk) disable iff (rst)
      refill_done_i |-> refill_req_i)
      else begin
         $error("refill_done_o raised outside refill_req_o");
         error_count++;
      end

   // First cycle out of reset is quiet
   quiet_after_reset: assert property (@(posedge clk)
      $fell(rst) |-> !(cpu_ack_i || refill_req_i || refill_done_i || spr_bus_ack_i))
      else begin
         $error("control output high in the cycle after reset");
         error_count++;
      end

endmodule

//--- sim/tb_dcache.sv
`timescale 1ns/1ps

module tb_dcache
   import dcache_spr_pkg::*;
();

   localparam int unsigned ROWS = 23;
   localparam int unsigned MEM_WORDS = 4096;
   localparam logic [31:0] FILL_PATTERN = 32'h6B1D_3CA5;
   localparam int unsigned TIMEOUT = 100;
   // The DUT must ignore this non-cache register
   localparam logic [15:0] SPR_OTHER_ADDR = 16'h3004;

   typedef enum logic [2:0] {K_READ, K_WRITE, K_INVAL, K_FLUSH, K_SPR_OTHER} kind_e;

   // One operation with its expectation
   typedef struct packed {
      kind_e       kind;
      logic [31:0] addr;
      logic [31:0] wdata;
      logic [3:0]  bsel;
      logic        refill;
   } row_t;

   logic        clk = 1'b0;
   logic        rst;
   logic        cpu_req_i;
   logic        cpu_we_i;
   logic [3:0]  cpu_bsel_i;
   logic [31:0] cpu_adr_i;
   logic [31:0] cpu_dat_i;
   logic [31:0] cpu_dat_o;
   logic        cpu_ack_o;
   logic        refill_req_o;
   logic        refill_done_o;
   logic        refill_we_i;
   logic [31:0] refill_adr_i;
   logic [31:0] refill_dat_i;
   logic        spr_bus_stb_i;
   logic        spr_bus_we_i;
   logic [15:0] spr_bus_addr_i;
   logic [31:0] spr_bus_dat_i;
   logic        spr_bus_ack_o;

   row_t        stim [ROWS];
   // Every address used stays below 0x4000 of backing memory
   logic [31:0] mem_model [MEM_WORDS];
   integer      seed;
   int          checks;
   int          mismatches;
   int          failures;
   bit          timed_out;

   always #2 clk = ~clk;

   dcache_top dut0 (.*);

   bind dcache_top dcache_chk chk0 (
      .clk           (clk),
      .rst           (rst),
      .cpu_req_i     (cpu_req_i),
      .cpu_ack_i     (cpu_ack_o),
      .spr_bus_stb_i (spr_bus_stb_i),
      .spr_bus_ack_i (spr_bus_ack_o),
      .refill_req_i  (refill_req_o),
      .refill_done_i (refill_done_o)
   );

   function automatic logic [31:0] model_word(input logic [31:0] addr);
      return mem_model[addr[13:2]];
   endfunction

   // Memory takes the selected bytes on hit and miss alike
   task automatic model_store(input logic [31:0] addr, input logic [31:0] data,
                              input logic [3:0] bsel);
      for (int b = 0; b < 4; b++) begin
         if (bsel[b]) begin
            mem_model[addr[13:2]][8*b +: 8] = data[8*b +: 8];
         end
      end
   endtask

   // Inputs change just after the rising edge
   task automatic step_cycle();
      @(posedge clk);
      #1;
   endtask

   task automatic check_equal(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
      checks++;
      assert (got === exp) else begin
         $display("Mismatch at %0t ns: %s got %h expected %h", $time, what, got, exp);
         mismatches++;
      end
   endtask

   // Read with a built-in refill responder
   task automatic read_word(input row_t r);
      logic [31:0] got;
      logic [1:0]  word;
      int          sent;
      int          cycles;
      bit          acked;
      bit          ack_early;
      bit          saw_refill;
      bit          done;
      got = '0;
      word = r.addr[3:2];
      sent = 0;
      cycles = 0;
      acked = 1'b0;
      ack_early = 1'b0;
      saw_refill = 1'b0;
      done = 1'b0;
      step_cycle();
      cpu_req_i = 1'b1;
      cpu_we_i = 1'b0;
      cpu_adr_i = r.addr;
      while (!(acked && (done || !saw_refill)) && cycles < TIMEOUT) begin
         // Outputs are sampled mid-cycle
         @(negedge clk);
         if (cpu_ack_o && cpu_req_i) begin
            acked = 1'b1;
            got = cpu_dat_o;
            ack_early = !(done || refill_done_o);
         end
         saw_refill |= refill_req_o;
         done |= refill_done_o;
         step_cycle();
         cycles++;
         refill_we_i = 1'b0;
         if (acked) begin
            cpu_req_i = 1'b0;
         end
         // Missed word comes first and the rest wrap with random idle gaps
         if (refill_req_o && !done && sent < 4 && ($random(seed) & 3) != 0) begin
            refill_adr_i = {r.addr[31:4], word + 2'(sent), 2'b00};
            refill_dat_i = model_word(refill_adr_i);
            refill_we_i = 1'b1;
            sent++;
         end
      end
      assert (acked && (done || !saw_refill)) else begin
         $display("Read of %h at %0t ns got no ack or its refill never ended",
                  r.addr, $time);
         failures++;
         timed_out = 1'b1;
      end
      if (!timed_out) begin
         check_equal($sformatf("read data at %h", r.addr), got, model_word(r.addr));
         check_equal($sformatf("refill flag for read of %h", r.addr),
                     {31'd0, saw_refill}, {31'd0, r.refill});
         // The requested word is acknowledged while the block is still arriving
         if (saw_refill) begin
            check_equal($sformatf("ack ahead of refill end for %h", r.addr),
                        {31'd0, ack_early}, 32'd1);
         end
      end
   endtask

   task automatic write_word(input row_t r);
      int cycles;
      bit acked;
      bit saw_refill;
      cycles = 0;
      acked = 1'b0;
      saw_refill = 1'b0;
      step_cycle();
      cpu_req_i = 1'b1;
      cpu_we_i = 1'b1;
      cpu_adr_i = r.addr;
      cpu_dat_i = r.wdata;
      cpu_bsel_i = r.bsel;
      while (!acked && cycles < TIMEOUT) begin
         @(negedge clk);
         acked = cpu_ack_o;
         saw_refill |= refill_req_o;
         step_cycle();
         cycles++;
      end
      cpu_req_i = 1'b0;
      cpu_we_i = 1'b0;
      assert (acked) else begin
         $display("Write to %h at %0t ns was never acknowledged", r.addr, $time);
         failures++;
         timed_out = 1'b1;
      end
      check_equal($sformatf("refill flag for write of %h", r.addr), {31'd0, saw_refill}, '0);
      model_store(r.addr, r.wdata, r.bsel);
   endtask

   // Data word carries a byte address in the set to clear
   task automatic write_spr(input logic [15:0] spr_addr, input logic [31:0] line_addr,
                            input bit expect_ack, input int limit);
      int cycles;
      bit acked;
      cycles = 0;
      acked = 1'b0;
      step_cycle();
      spr_bus_stb_i = 1'b1;
      spr_bus_we_i = 1'b1;
      spr_bus_addr_i = spr_addr;
      spr_bus_dat_i = line_addr;
      while (!acked && cycles < limit) begin
         @(negedge clk);
         acked = spr_bus_ack_o;
         step_cycle();
         cycles++;
      end
      spr_bus_stb_i = 1'b0;
      spr_bus_we_i = 1'b0;
      if (expect_ack) begin
         assert (acked) else begin
            $display("SPR write to %h at %0t ns was never acknowledged", spr_addr, $time);
            failures++;
            timed_out = 1'b1;
         end
      end else begin
         assert (!acked) else begin
            $display("SPR write to %h at %0t ns was acknowledged but should not be",
                     spr_addr, $time);
            failures++;
         end
      end
   endtask

   initial begin
      seed = 5424;
      checks = 0;
      mismatches = 0;
      failures = 0;
      timed_out = 1'b0;
      rst = 1'b1;
      cpu_req_i = 1'b0;
      cpu_we_i = 1'b0;
      cpu_bsel_i = '0;
      cpu_adr_i = '0;
      cpu_dat_i = '0;
      refill_we_i = 1'b0;
      refill_adr_i = '0;
      refill_dat_i = '0;
      spr_bus_stb_i = 1'b0;
      spr_bus_we_i = 1'b0;
      spr_bus_addr_i = '0;
      spr_bus_dat_i = '0;
      for (int i = 0; i < MEM_WORDS; i++) begin
         mem_model[i] = (32'(i) << 2) ^ FILL_PATTERN;
      end
      // First read fills and the repeat hits
      stim[0]  = '{K_READ,      32'h0000_0100, 32'h0,         4'h0, 1'b1};
      stim[1]  = '{K_READ,      32'h0000_0100, 32'h0,         4'h0, 1'b0};
      // Miss on a middle word before every word of the block hits
      stim[2]  = '{K_READ,      32'h0000_0208, 32'h0,         4'h0, 1'b1};
      stim[3]  = '{K_READ,      32'h0000_0200, 32'h0,         4'h0, 1'b0};
      stim[4]  = '{K_READ,      32'h0000_0204, 32'h0,         4'h0, 1'b0};
      stim[5]  = '{K_READ,      32'h0000_0208, 32'h0,         4'h0, 1'b0};
      stim[6]  = '{K_READ,      32'h0000_020C, 32'h0,         4'h0, 1'b0};
      // Partial write hit on bytes 0 and 2
      stim[7]  = '{K_WRITE,     32'h0000_0204, 32'hA5A5_5A5A, 4'h5, 1'b0};
      stim[8]  = '{K_READ,      32'h0000_0204, 32'h0,         4'h0, 1'b0};
      // Write miss allocates nothing
      stim[9]  = '{K_WRITE,     32'h0000_0300, 32'h1234_5678, 4'hF, 1'b0};
      stim[10] = '{K_READ,      32'h0000_0300, 32'h0,         4'h0, 1'b1};
      // Lines A, B, C share set 4
      stim[11] = '{K_READ,      32'h0000_1040, 32'h0,         4'h0, 1'b1};
      stim[12] = '{K_READ,      32'h0000_2040, 32'h0,         4'h0, 1'b1};
      stim[13] = '{K_READ,      32'h0000_1040, 32'h0,         4'h0, 1'b0};
      stim[14] = '{K_READ,      32'h0000_3044, 32'h0,         4'h0, 1'b1};
      stim[15] = '{K_READ,      32'h0000_1040, 32'h0,         4'h0, 1'b0};
      stim[16] = '{K_READ,      32'h0000_2040, 32'h0,         4'h0, 1'b1};
      // Unrelated SPR leaves the line alone
      stim[17] = '{K_SPR_OTHER, 32'h0000_0100, 32'h0,         4'h0, 1'b0};
      stim[18] = '{K_READ,      32'h0000_0100, 32'h0,         4'h0, 1'b0};
      stim[19] = '{K_INVAL,     32'h0000_0100, 32'h0,         4'h0, 1'b0};
      stim[20] = '{K_READ,      32'h0000_0100, 32'h0,         4'h0, 1'b1};
      stim[21] = '{K_FLUSH,     32'h0000_020C, 32'h0,         4'h0, 1'b0};
      stim[22] = '{K_READ,      32'h0000_0200, 32'h0,         4'h0, 1'b1};
      repeat (4) @(posedge clk);
      #1;
      rst = 1'b0;
      // Tag RAM starts undefined so every set is cleared
      for (int s = 0; s < 64 && !timed_out; s++) begin
         write_spr((s % 2) ? SPR_DCBFR_ADDR : SPR_DCBIR_ADDR, 32'(s * 16), 1'b1, TIMEOUT);
      end
      for (int i = 0; i < ROWS && !timed_out; i++) begin
         case (stim[i].kind)
            K_READ:      read_word(stim[i]);
            K_WRITE:     write_word(stim[i]);
            K_INVAL:     write_spr(SPR_DCBIR_ADDR, stim[i].addr, 1'b1, TIMEOUT);
            K_FLUSH:     write_spr(SPR_DCBFR_ADDR, stim[i].addr, 1'b1, TIMEOUT);
            default:     write_spr(SPR_OTHER_ADDR, stim[i].addr, 1'b0, 16);
         endcase
      end
      step_cycle();
      // Protocol properties of the bound checker count as failures too
      failures += dut0.chk0.error_count;
      $display("Checks %0d, mismatches %0d, other failures %0d", checks, mismatches, failures);
      if (mismatches == 0 && failures == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

//--- sources.f
source/dcache_geom_pkg.sv
source/dcache_spr_pkg.sv
source/dcache_sdpram.sv
source/dcache_tag_lookup.sv
source/dcache_data_ways.sv
source/dcache_ctrl.sv
source/dcache_top.sv
sim/dcache_chk.sv
sim/tb_dcache.sv

//--- Bender.yml
package:
  name: dcache

sources:
  - source/dcache_geom_pkg.sv
  - source/dcache_spr_pkg.sv
  - source/dcache_sdpram.sv
  - source/dcache_tag_lookup.sv
  - source/dcache_data_ways.sv
  - source/dcache_ctrl.sv
  - source/dcache_top.sv
  - target: simulation
    files:
      - sim/dcache_chk.sv
      - sim/tb_dcache.sv
